// File: debug_unit.f
+incdir+src
src/debug_unit_pkg.sv
src/dbg_mem_if.sv
src/dbg_cmd_fsm.sv
src/dbg_tx_engine.sv
src/dbg_mem_reader.sv
src/debug_unit.sv
verification/debug_unit_tb.sv

// File: src/dbg_cmd_fsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "debug_unit_cfg.svh"

module dbg_cmd_fsm
	import debug_unit_pkg::*;
(
	input  wire    clk,
	input  wire    rst_n_i,
	input  byte_t  rx_data_i,
	input  wire    rx_empty_i,
	input  wire    pipe_halt_i,
	input  wire    reply_done_i,
	output logic   rd_o,
	output logic   pipe_run_o,
	output logic   pipe_restart_o,
	output logic   reply_start_o,
	output reply_e reply_kind_o
);

	localparam int HOLD_W = $clog2(`RESTART_CYCLES + 1);

	cmd_state_e         state;
	logic [HOLD_W-1:0]  hold_cnt;

	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
		begin
			state          <= ST_IDLE;
			rd_o           <= 1'b0;
			pipe_run_o     <= 1'b0;
			pipe_restart_o <= 1'b0;
			reply_start_o  <= 1'b0;
			reply_kind_o   <= REPLY_DUMP;
			hold_cnt       <= '0;
		end
		else
		begin
			rd_o          <= 1'b0;
			reply_start_o <= 1'b0;
			case (state)
				ST_IDLE:
				begin
					if (!rx_empty_i)
					begin
						rd_o  <= 1'b1;
						state <= ST_READ;
					end
				end
				ST_READ: // Byte is consumed in this cycle
				begin
					case (rx_data_i)
						`CMD_STEP:
						begin
							pipe_run_o <= 1'b1;
							state      <= ST_STEP;
						end
						`CMD_CONT:
						begin
							pipe_run_o <= 1'b1;
							state      <= ST_RUN;
						end
						`CMD_RESET:
						begin
							reply_start_o <= 1'b1;
							reply_kind_o  <= REPLY_RST;
							state         <= ST_REPLY;
						end
						default:
						begin
							reply_start_o <= 1'b1;
							reply_kind_o  <= REPLY_ERR;
							state         <= ST_REPLY;
						end
					endcase
				end
				ST_STEP, ST_RUN:
				begin
					if (state == ST_STEP || pipe_halt_i)
					begin
						pipe_run_o    <= 1'b0;
						reply_start_o <= 1'b1;
						reply_kind_o  <= REPLY_DUMP;
						state         <= ST_REPLY;
					end
				end
				ST_REPLY:
				begin
					if (reply_done_i)
					begin
						if (reply_kind_o == REPLY_RST)
						begin
							pipe_run_o     <= 1'b1;
							pipe_restart_o <= 1'b1;
							hold_cnt       <= '0;
							state          <= ST_HOLD;
						end
						else
							state <= ST_IDLE;
					end
				end
				ST_HOLD: // Pipeline restart without command intake
				begin
					if (hold_cnt == HOLD_W'(`RESTART_CYCLES - 1))
					begin
						pipe_run_o     <= 1'b0;
						pipe_restart_o <= 1'b0;
						state          <= ST_IDLE;
					end
					else
						hold_cnt <= hold_cnt + 1'b1;
				end
				default:
					state <= ST_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: src/dbg_mem_if.sv
`timescale 1ns/1ps
`default_nettype none

// Word fetch between the transmitter and the memory reader
interface dbg_mem_if
	import debug_unit_pkg::*;
();

	logic        fetch_req;   // One-cycle strobe
	logic [1:0]  word_idx;    // Word offset within the dump
	word_t       word;
	logic        word_valid;  // One-cycle strobe with word held afterwards

	modport tx
	(
		output fetch_req,
		output word_idx,
		input  word,
		input  word_valid
	);

	modport rdr
	(
		input  fetch_req,
		input  word_idx,
		output word,
		output word_valid
	);

endinterface

`default_nettype wire

// File: src/dbg_mem_reader.sv
`timescale 1ns/1ps
`default_nettype none

`include "debug_unit_cfg.svh"

module dbg_mem_reader
	import debug_unit_pkg::*;
(
	input  wire       clk,
	input  wire       rst_n_i,
	input  word_t     mem_data_i,
	output logic      mem_rd_o,
	output mem_addr_t mem_addr_o,
	dbg_mem_if.rdr    mem
);

	localparam int LAT_W = $clog2(`MEM_LATENCY + 1);

	logic [LAT_W-1:0] lat_cnt;

	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
		begin
			mem_rd_o       <= 1'b0;
			mem.word_valid <= 1'b0;
			lat_cnt        <= '0;
		end
		else
		begin
			mem.word_valid <= 1'b0;
			if (mem.fetch_req)
			begin
				mem_rd_o <= 1'b1;
				lat_cnt  <= '0;
			end
			else if (mem_rd_o)
			begin
				if (lat_cnt == LAT_W'(`MEM_LATENCY - 1)) // Data due on this edge
				begin
					mem_rd_o       <= 1'b0;
					mem.word_valid <= 1'b1;
				end
				else
					lat_cnt <= lat_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (mem.fetch_req)
			mem_addr_o <= mem_addr_t'(`MEM_BASE + 1) + mem_addr_t'(mem.word_idx);
		if (mem_rd_o && lat_cnt == LAT_W'(`MEM_LATENCY - 1))
			mem.word <= mem_data_i;
	end

endmodule

`default_nettype wire

// File: src/dbg_tx_engine.sv
`timescale 1ns/1ps
`default_nettype none

`include "debug_unit_cfg.svh"

module dbg_tx_engine
	import debug_unit_pkg::*;
(
	input  wire    clk,
	input  wire    rst_n_i,
	input  wire    tx_full_i,
	input  snap_t  snapshot_i,
	input  wire    reply_start_i,
	input  reply_e reply_kind_i,
	output byte_t  tx_data_o,
	output logic   wr_o,
	output logic   reply_done_o,
	dbg_mem_if.tx  mem
);

	tx_state_e  state;
	byte_idx_t  byte_idx;   // Position in the current segment
	logic [1:0] word_cnt;
	logic       gap_q;      // Write issued last cycle
	reply_e     kind_q;
	byte_t      lead_chr;
	logic       sending;

	//////////////////////////////
	// Byte selection

	always_comb
	begin
		case (kind_q)
			REPLY_ERR: lead_chr = `CHR_ERR;
			REPLY_RST: lead_chr = `CHR_RST;
			default:   lead_chr = `CHR_FIN;
		endcase
	end

	always_comb
	begin
		case (state)
			TX_SNAP:  tx_data_o = snapshot_i[byte_idx * 8 +: 8];
			TX_WORD:  tx_data_o = mem.word[byte_idx[1:0] * 8 +: 8];  // Low byte first
			TX_TRAIL: tx_data_o = (byte_idx == '0) ? lead_chr : `CHR_NL;
			default:  tx_data_o = '0;
		endcase
	end

	assign sending = (state == TX_SNAP) || (state == TX_WORD) || (state == TX_TRAIL);
	assign wr_o    = sending && !tx_full_i && !gap_q;

	assign mem.fetch_req = (state == TX_FETCH);
	assign mem.word_idx  = word_cnt;

	//////////////////////////////
	// Sequencing

	always_ff @(posedge clk)
	begin
		if (state == TX_IDLE && reply_start_i)
			kind_q <= reply_kind_i;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
		begin
			state        <= TX_IDLE;
			byte_idx     <= '0;
			word_cnt     <= '0;
			gap_q        <= 1'b0;
			reply_done_o <= 1'b0;
		end
		else
		begin
			gap_q        <= wr_o;
			reply_done_o <= 1'b0;
			case (state)
				TX_IDLE:
				begin
					byte_idx <= '0;
					word_cnt <= '0;
					if (reply_start_i)
						state <= (reply_kind_i == REPLY_DUMP) ? TX_SNAP : TX_TRAIL;
				end
				TX_SNAP:
				begin
					if (wr_o)
					begin
						if (byte_idx == byte_idx_t'(`SNAP_BYTES - 1))
						begin
							byte_idx <= '0;
							state    <= TX_FETCH;
						end
						else
							byte_idx <= byte_idx + 1'b1;
					end
				end
				TX_FETCH:
					state <= TX_WAIT;
				TX_WAIT:
				begin
					if (mem.word_valid)
						state <= TX_WORD;
				end
				TX_WORD:
				begin
					if (wr_o)
					begin
						if (byte_idx == byte_idx_t'(3))
						begin
							byte_idx <= '0;
							if (word_cnt == 2'(`MEM_WORDS - 1))
								state <= TX_TRAIL;
							else
							begin
								word_cnt <= word_cnt + 1'b1;
								state    <= TX_FETCH;
							end
						end
						else
							byte_idx <= byte_idx + 1'b1;
					end
				end
				TX_TRAIL:
				begin
					if (wr_o)
					begin
						if (byte_idx == byte_idx_t'(1))
						begin
							reply_done_o <= 1'b1;
							state        <= TX_IDLE;
						end
						else
							byte_idx <= byte_idx + 1'b1;
					end
				end
				default:
					state <= TX_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: src/debug_unit.sv
`timescale 1ns/1ps
`default_nettype none

module debug_unit
	import debug_unit_pkg::*;
(
	input  wire       clk,
	input  wire       rst_n_i,
	input  byte_t     rx_data_i,
	input  wire       rx_empty_i,
	input  wire       tx_full_i,
	input  wire       pipe_halt_i,
	input  snap_t     snapshot_i,
	input  word_t     mem_data_i,
	output logic      rd_o,
	output byte_t     tx_data_o,
	output logic      wr_o,
	output logic      pipe_run_o,
	output logic      pipe_restart_o,
	output logic      mem_rd_o,
	output mem_addr_t mem_addr_o
);

	logic   reply_start;
	reply_e reply_kind;
	logic   reply_done;

	dbg_mem_if mem_bus ();

	dbg_cmd_fsm u_cmd_fsm
	(
		.clk            (clk),
		.rst_n_i        (rst_n_i),
		.rx_data_i      (rx_data_i),
		.rx_empty_i     (rx_empty_i),
		.pipe_halt_i    (pipe_halt_i),
		.reply_done_i   (reply_done),
		.rd_o           (rd_o),
		.pipe_run_o     (pipe_run_o),
		.pipe_restart_o (pipe_restart_o),
		.reply_start_o  (reply_start),
		.reply_kind_o   (reply_kind)
	);

	dbg_tx_engine u_tx_engine
	(
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.tx_full_i     (tx_full_i),
		.snapshot_i    (snapshot_i),
		.reply_start_i (reply_start),
		.reply_kind_i  (reply_kind),
		.tx_data_o     (tx_data_o),
		.wr_o          (wr_o),
		.reply_done_o  (reply_done),
		.mem           (mem_bus.tx)
	);

	dbg_mem_reader u_mem_reader
	(
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.mem_data_i (mem_data_i),
		.mem_rd_o   (mem_rd_o),
		.mem_addr_o (mem_addr_o),
		.mem        (mem_bus.rdr)
	);

endmodule

`default_nettype wire

// File: src/debug_unit_cfg.svh
`ifndef DEBUG_UNIT_CFG_SVH
`define DEBUG_UNIT_CFG_SVH

// Dump layout
`define SNAP_BYTES      16
`define MEM_WORDS       4
`define MEM_BASE        79   // First word read at base+1
`define MEM_LATENCY     4
`define RESTART_CYCLES  3

// Command bytes
`define CMD_CONT        8'h43
`define CMD_STEP        8'h50
`define CMD_RESET       8'h52

// Reply bytes
`define CHR_ERR         8'h45
`define CHR_RST         8'h52
`define CHR_FIN         8'h46
`define CHR_NL          8'h0A

`endif

// File: src/debug_unit_pkg.sv
`default_nettype none

`include "debug_unit_cfg.svh"

package debug_unit_pkg;

	typedef logic [7:0]                 byte_t;      // FIFO byte
	typedef logic [31:0]                word_t;      // Data memory word
	typedef logic [11:0]                mem_addr_t;
	typedef logic [`SNAP_BYTES*8-1:0]   snap_t;      // Packed processor state
	typedef logic [7:0]                 byte_idx_t;

	typedef enum logic [1:0]
	{
		REPLY_DUMP,
		REPLY_ERR,
		REPLY_RST
	} reply_e;

	typedef enum logic [2:0]
	{
		ST_IDLE,
		ST_READ,
		ST_STEP,
		ST_RUN,
		ST_REPLY,
		ST_HOLD
	} cmd_state_e;

	typedef enum logic [2:0]
	{
		TX_IDLE,
		TX_SNAP,
		TX_FETCH,
		TX_WAIT,
		TX_WORD,
		TX_TRAIL
	} tx_state_e;

endpackage

`default_nettype wire

// File: verification/debug_unit_input.txt
// One test per line, all fields in hex
// Columns: command byte, snapshot fill value, run cycles before halt (used for 43 only)
50 a5 00
43 3c 05
52 00 00
45 00 00
43 c7 01
50 0f 00
ff 00 00
52 00 00
43 81 0c
70 00 00

// File: verification/debug_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "debug_unit_cfg.svh"

module debug_unit_tb
	import debug_unit_pkg::*;
();

	localparam int NUM_TESTS  = 10;    // Lines in the input file
	localparam int WAIT_LIMIT = 2000;

	logic      clk;
	logic      rst_n_i;
	byte_t     rx_data_i;
	logic      rx_empty_i;
	logic      tx_full_i;
	logic      pipe_halt_i;
	snap_t     snapshot_i;
	word_t     mem_data_i;
	logic      rd_o;
	byte_t     tx_data_o;
	logic      wr_o;
	logic      pipe_run_o;
	logic      pipe_restart_o;
	logic      mem_rd_o;
	mem_addr_t mem_addr_o;

	byte_t     stim [0:3*NUM_TESTS-1];
	byte_t     tx_q [$];               // Transmit FIFO contents
	int        mem_age;                // Cycles since mem_addr_o was presented
	int        wr_cnt;
	int        run_cnt;
	int        restart_cnt;
	int        halt_after;             // Zero disables the halt source
	int        run_seen;
	logic      stall_en;
	logic      last_wr;
	int        errors;
	int        tests;
	int        failed_tests;
	logic      aborted;

	initial
	begin
		clk = 1'b0;
		forever
			#5 clk = ~clk;
	end

	debug_unit UUT
	(
		.clk            (clk),
		.rst_n_i        (rst_n_i),
		.rx_data_i      (rx_data_i),
		.rx_empty_i     (rx_empty_i),
		.tx_full_i      (tx_full_i),
		.pipe_halt_i    (pipe_halt_i),
		.snapshot_i     (snapshot_i),
		.mem_data_i     (mem_data_i),
		.rd_o           (rd_o),
		.tx_data_o      (tx_data_o),
		.wr_o           (wr_o),
		.pipe_run_o     (pipe_run_o),
		.pipe_restart_o (pipe_restart_o),
		.mem_rd_o       (mem_rd_o),
		.mem_addr_o     (mem_addr_o)
	);

	// Memory word holds the address and its inverse
	function automatic word_t mem_word(input mem_addr_t addr);
		return {4'hC, addr, 4'h3, ~addr};
	endfunction

	function automatic byte_t snap_byte(input byte_t fill, input int k);
		return fill ^ byte_t'(k * 29);
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] want);
		if (got !== want)
		begin
			errors++;
			$display("ERROR %s: got 0x%h, expected 0x%h", name, got, want);
		end
	endtask

	task automatic log_fault(input string what);
		errors++;
		$display("%s", what);
	endtask

	task automatic give_up(input string what);
		errors++;
		aborted = 1'b1;
		$display("Timeout while waiting for %s", what);
	endtask

	//////////////////////////////
	// Models and monitor

	always @(posedge clk)
	begin
		if (mem_rd_o)
			mem_age <= mem_age + 1;
		else
			mem_age <= 0;
		if (mem_rd_o && mem_age == `MEM_LATENCY - 2)
			mem_data_i <= mem_word(mem_addr_o);   // Valid for the capture edge only
		else
			mem_data_i <= ~mem_word(mem_addr_o);
	end

	always @(posedge clk)
	begin
		if (!pipe_run_o)
		begin
			run_seen    <= 0;
			pipe_halt_i <= 1'b0;
		end
		else if (halt_after != 0)
		begin
			run_seen <= run_seen + 1;
			if (run_seen + 1 >= halt_after)
				pipe_halt_i <= 1'b1;
		end
	end

	always @(posedge clk)
	begin
		if (stall_en)
			tx_full_i <= ($urandom % 3) == 0;
		else
			tx_full_i <= 1'b0;
	end

	always @(posedge clk)
	begin
		last_wr <= wr_o;
		if (rst_n_i)
		begin
			if (wr_o)
			begin
				tx_q.push_back(tx_data_o);
				wr_cnt <= wr_cnt + 1;
				if (tx_full_i)
					log_fault("Write to the transmit FIFO while it was full");
				if (last_wr)
					log_fault("Two transmit FIFO writes in consecutive cycles");
			end
			if (rd_o && rx_empty_i)
				log_fault("Read from the receive FIFO while it was empty");
			if (pipe_run_o)
				run_cnt <= run_cnt + 1;
			if (pipe_restart_o)
				restart_cnt <= restart_cnt + 1;
		end
	end

	//////////////////////////////
	// Stimulus

	// One-entry receive FIFO whose byte leaves on the edge that samples rd_o
	task automatic send_command(input byte_t cmd);
		int n;
		@(posedge clk);
		rx_data_i  <= cmd;
		rx_empty_i <= 1'b0;
		n = 0;
		@(posedge clk);
		while (!rd_o && n < WAIT_LIMIT)
		begin
			@(posedge clk);
			n++;
		end
		rx_empty_i <= 1'b1;
		if (!rd_o)
			give_up("rd_o after a command byte");
	endtask

	task automatic run_test(input byte_t cmd, input byte_t fill, input byte_t cycles);
		byte_t want [$];
		snap_t snap;
		word_t w;
		int    wr_start;
		int    run_start;
		int    rst_start;
		int    err_start;
		int    exp_run;
		int    exp_rst;
		int    n;
		err_start = errors;
		exp_run   = 0;
		exp_rst   = 0;
		if (cmd == `CMD_STEP || cmd == `CMD_CONT)
		begin
			for (int k = 0; k < `SNAP_BYTES; k++)
				want.push_back(snap_byte(fill, k));
			for (int i = 0; i < `MEM_WORDS; i++)
			begin
				w = mem_word(mem_addr_t'(`MEM_BASE + 1 + i));
				for (int b = 0; b < 4; b++)
					want.push_back(w[b*8 +: 8]);
			end
			want.push_back(`CHR_FIN);
			want.push_back(`CHR_NL);
			exp_run = (cmd == `CMD_STEP) ? 1 : cycles + 1;  // Plus the cycle that samples halt
		end
		else if (cmd == `CMD_RESET)
		begin
			want.push_back(`CHR_RST);
			want.push_back(`CHR_NL);
			exp_run = `RESTART_CYCLES;
			exp_rst = `RESTART_CYCLES;
		end
		else
		begin
			want.push_back(`CHR_ERR);
			want.push_back(`CHR_NL);
		end

		for (int k = 0; k < `SNAP_BYTES; k++)
			snap[k*8 +: 8] = snap_byte(fill, k);
		@(posedge clk);
		snapshot_i <= snap;
		halt_after <= (cmd == `CMD_CONT) ? int'(cycles) : 0;
		wr_start  = wr_cnt;
		run_start = run_cnt;
		rst_start = restart_cnt;
		send_command(cmd);

		n = 0;
		while (!aborted && wr_cnt - wr_start < want.size() && n < WAIT_LIMIT)
		begin
			@(posedge clk);
			n++;
		end
		if (!aborted && wr_cnt - wr_start < want.size())
			give_up("the reply bytes");

		if (!aborted && cmd == `CMD_RESET)
		begin
			n = 0;
			while (!pipe_restart_o && n < WAIT_LIMIT)
			begin
				@(posedge clk);
				n++;
			end
			if (!pipe_restart_o)
				give_up("pipe_restart_o to rise");
			n = 0;
			while (!aborted && pipe_restart_o && n < WAIT_LIMIT)
			begin
				@(posedge clk);
				n++;
			end
			if (pipe_restart_o)
				give_up("pipe_restart_o to fall");
		end

		if (!aborted)
		begin
			for (int i = 0; i < want.size(); i++)
				check_value($sformatf("tx_data_o byte %0d", i), tx_q.pop_front(), want[i]);
			check_value("pipe_run_o cycles", run_cnt - run_start, exp_run);
			check_value("pipe_restart_o cycles", restart_cnt - rst_start, exp_rst);
		end
		tests++;
		if (errors != err_start)
			failed_tests++;
		$display("Case %0d  cmd 0x%h  stalls %0d  %s", tests, cmd, stall_en,
			(errors == err_start) ? "passed" : "failed");
	endtask

	initial
	begin
		void'($urandom(92));
		rst_n_i      = 1'b0;
		rx_data_i    = '0;
		rx_empty_i   = 1'b1;
		tx_full_i    = 1'b0;
		pipe_halt_i  = 1'b0;
		snapshot_i   = '0;
		mem_data_i   = '0;
		stall_en     = 1'b0;
		last_wr      = 1'b0;
		mem_age      = 0;
		halt_after   = 0;
		run_seen     = 0;
		wr_cnt       = 0;
		run_cnt      = 0;
		restart_cnt  = 0;
		errors       = 0;
		tests        = 0;
		failed_tests = 0;
		aborted      = 1'b0;
		$readmemh("verification/debug_unit_input.txt", stim);

		repeat (8) @(posedge clk);
		rst_n_i <= 1'b1;
		@(posedge clk);
		check_value("rd_o", rd_o, 0);
		check_value("wr_o", wr_o, 0);
		check_value("mem_rd_o", mem_rd_o, 0);
		check_value("pipe_run_o", pipe_run_o, 0);
		check_value("pipe_restart_o", pipe_restart_o, 0);
		repeat (10) @(posedge clk);   // Idle window with an empty receive FIFO
		tests++;
		if (errors != 0)
			failed_tests++;
		$display("Case %0d  reset and idle  %s", tests, (errors == 0) ? "passed" : "failed");

		// Second round adds random back-pressure
		for (int round = 0; round < 2 && !aborted; round++)
		begin
			stall_en <= (round == 1);
			for (int t = 0; t < NUM_TESTS && !aborted; t++)
				run_test(stim[3*t], stim[3*t+1], stim[3*t+2]);
		end

		stall_en <= 1'b0;
		repeat (10) @(posedge clk);
		check_value("unexpected transmit bytes", tx_q.size(), 0);
		$display("%0d cases, %0d failed, %0d errors", tests, failed_tests, errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire
